// File: Bender.yml
package:
  name: store_commit

sources:
  - files:
      - src/dcache_pkg.sv
      - src/stq_pkg.sv
      - src/store_req_queue.sv
      - src/store_data_buf.sv
      - src/store_issue.sv
      - src/store_port_stage.sv
      - src/store_commit_top.sv
  - target: simulation
    files:
      - sim/store_commit_checker.sv
      - sim/tb_store_commit.sv

// File: compile.f
src/dcache_pkg.sv
src/stq_pkg.sv
src/store_req_queue.sv
src/store_data_buf.sv
src/store_issue.sv
src/store_port_stage.sv
src/store_commit_top.sv
sim/store_commit_checker.sv
sim/tb_store_commit.sv

// File: sim/store_commit_checker.sv
`timescale 1ns/1ps

module store_commit_checker #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_en,
  input  stq_pkg::st_req_t  req,
  input  logic              req_full,
  input  logic              wdata_en,
  input  stq_pkg::wq_idx_t  wdata_wq,
  input  stq_pkg::st_data_t wdata,
  input  logic              st_stall,
  input  logic [3:0]        agu_hold,
  input  logic              st0_en,
  input  stq_pkg::st_port_t st0,
  input  logic              st1_en,
  input  stq_pkg::st_port_t st1,
  output int                errors,
  output int                seen
);
  import dcache_pkg::*;
  import stq_pkg::*;

  st_req_t  model_q [$];
  st_data_t slot_data [WQ_ENTRIES];
  logic     hold_d1  = 1'b0;
  logic     stall_d1 = 1'b0;
  logic     stall_d2 = 1'b0;
  st_req_t  e0;
  st_req_t  e1;
  logic     got0;
  logic     got1;

  initial begin
    errors = 0;
    seen   = 0;
  end

  function automatic int last_byte(st_req_t r);
    int len;
    case (r.size)
      2'd0:    len = 1;
      2'd1:    len = 2;
      default: len = 4;
    endcase
    return int'(r.addr[1:0]) + len - 1;
  endfunction

  function automatic bank_mask_t banks_used(st_req_t r);
    bank_mask_t m;
    int         first;
    first    = r.addr[6:2];
    m        = '0;
    m[first] = 1'b1;
    if (last_byte(r) > 3) begin
      m[(first + 1) % NUM_BANKS] = 1'b1;
    end
    return m;
  endfunction

  function automatic st_port_t expect_port(st_req_t r, st_data_t d);
    st_port_t p;
    int       low;
    int       last;
    low    = r.addr[1:0];
    last   = last_byte(r);
    p      = '0;
    p.addr = r.addr;
    for (int i = low; i <= last && i < BANK_BYTES; i++) begin
      p.bgn_ben[i] = 1'b1;
    end
    // bytes past the first bank land at the bottom of the next one
    for (int i = BANK_BYTES; i <= last; i++) begin
      p.end_ben[i - BANK_BYTES] = 1'b1;
    end
    if (last >= BANK_BYTES) begin
      p.end_bank = bank_t'((int'(r.addr[6:2]) + 1) % NUM_BANKS);
    end else begin
      p.end_bank = r.addr[6:2];
    end
    p.data = port_data_t'(d) << (8 * low);
    return p;
  endfunction

  task automatic report_error(string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic compare_value(string test, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s: expected %0h, actual %0h", test, exp, act);
      errors++;
    end
  endtask

  task automatic check_port(string name, st_port_t act, st_req_t r);
    st_port_t exp;
    exp = expect_port(r, slot_data[r.wq]);
    compare_value({name, "_addr"}, 64'(exp.addr), 64'(act.addr));
    compare_value({name, "_bgn_ben"}, 64'(exp.bgn_ben), 64'(act.bgn_ben));
    compare_value({name, "_end_ben"}, 64'(exp.end_ben), 64'(act.end_ben));
    compare_value({name, "_end_bank"}, 64'(exp.end_bank), 64'(act.end_bank));
    compare_value({name, "_data"}, exp.data, act.data);
    seen++;
  endtask

  // inputs are stable at the rising edge
  always @(posedge clk) begin
    hold_d1  = |agu_hold;
    stall_d2 = stall_d1;
    stall_d1 = st_stall;
    // model occupancy here equals the queue occupancy before this edge
    if (rst_n && req_en && model_q.size() < QUEUE_DEPTH) begin
      model_q.push_back(req);
    end
    if (rst_n && wdata_en) begin
      slot_data[wdata_wq] = wdata;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    got0 = 1'b0;
    got1 = 1'b0;
    if (rst_n !== 1'b1) begin
      if (st0_en || st1_en) begin
        report_error("store port enabled during reset");
      end
    end else begin
      if (st1_en && !st0_en) begin
        report_error("st1_en high without st0_en");
      end
      if ((st0_en || st1_en) && hold_d1) begin
        report_error("store reached a port one cycle after an active hold");
      end
      if ((st0_en || st1_en) && stall_d2) begin
        report_error("store reached a port two cycles after st_stall");
      end
      if (st0_en) begin
        if (model_q.size() == 0) begin
          report_error("store on port 0 with no request outstanding");
        end else begin
          e0   = model_q.pop_front();
          got0 = 1'b1;
          check_port("st0", st0, e0);
        end
      end
      if (st1_en) begin
        if (model_q.size() == 0) begin
          report_error("store on port 1 with no request outstanding");
        end else begin
          e1   = model_q.pop_front();
          got1 = 1'b1;
          check_port("st1", st1, e1);
        end
      end
      if (got0 && got1) begin
        compare_value("pair_banks", 64'd0, 64'(banks_used(e0) & banks_used(e1)));
      end
      // stores not yet on a port are exactly the ones still queued
      compare_value("req_full", 64'(model_q.size() == QUEUE_DEPTH), 64'(req_full));
    end
  end

endmodule

// File: sim/tb_store_commit.sv
`timescale 1ns/1ps

module tb_store_commit;
  import dcache_pkg::*;
  import stq_pkg::*;

  localparam int QUEUE_DEPTH    = 8;
  localparam int NUM_REQ        = 300;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 20;

  logic                  clk;
  logic                  rst_n;
  logic                  req_en;
  st_req_t               req;
  logic                  req_full;
  logic                  wdata_en;
  wq_idx_t               wdata_wq;
  st_data_t              wdata;
  logic                  st_stall;
  logic [3:0]            agu_hold;
  logic                  st0_en;
  st_port_t              st0;
  logic                  st1_en;
  st_port_t              st1;
  int                    errors;
  int                    seen;
  integer                seed;
  int                    cycles;
  int                    sent;
  // cycles left until the data write, -1 when none is pending
  int                    wait_cnt [WQ_ENTRIES];
  logic [WQ_ENTRIES-1:0] busy;
  wq_idx_t               inflight [$];

  store_commit_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_en  (req_en),
    .req     (req),
    .req_full(req_full),
    .wdata_en(wdata_en),
    .wdata_wq(wdata_wq),
    .wdata   (wdata),
    .st_stall(st_stall),
    .agu_hold(agu_hold),
    .st0_en  (st0_en),
    .st0     (st0),
    .st1_en  (st1_en),
    .st1     (st1)
  );

  store_commit_checker #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_checker (.*);

  function automatic int rand_below(int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  function automatic int pending_writes();
    int n;
    n = 0;
    for (int i = 0; i < WQ_ENTRIES; i++) begin
      if (wait_cnt[i] >= 0) begin
        n++;
      end
    end
    return n;
  endfunction

  // stores leave the ports in request order, so their slots free up in that order
  task automatic free_slots();
    wq_idx_t done_wq;
    if (st0_en && inflight.size() > 0) begin
      done_wq       = inflight.pop_front();
      busy[done_wq] = 1'b0;
    end
    if (st1_en && inflight.size() > 0) begin
      done_wq       = inflight.pop_front();
      busy[done_wq] = 1'b0;
    end
  endtask

  task automatic drive_cycle();
    int start;
    int s;
    agu_hold = (rand_below(10) == 0) ? (4'b0001 << rand_below(4)) : 4'b0000;
    st_stall = (rand_below(10) == 0);
    req_en   = 1'b0;
    wdata_en = 1'b0;
    for (int i = 0; i < WQ_ENTRIES; i++) begin
      if (wait_cnt[i] > 0) begin
        wait_cnt[i]--;
      end
    end
    start = rand_below(WQ_ENTRIES);
    if (sent < NUM_REQ && !req_full && rand_below(4) != 0) begin
      for (int i = 0; i < WQ_ENTRIES; i++) begin
        s = (start + i) % WQ_ENTRIES;
        if (!busy[s] && !req_en) begin
          req_en      = 1'b1;
          req.addr    = $random(seed);
          req.size    = st_size_t'(rand_below(3));
          req.wq      = wq_idx_t'(s);
          busy[s]     = 1'b1;
          wait_cnt[s] = rand_below(6);
          inflight.push_back(wq_idx_t'(s));
          sent++;
        end
      end
    end
    // one data write per cycle, lowest due slot first
    for (int i = 0; i < WQ_ENTRIES; i++) begin
      if (wait_cnt[i] == 0 && !wdata_en) begin
        wdata_en    = 1'b1;
        wdata_wq    = wq_idx_t'(i);
        wdata       = $random(seed);
        wait_cnt[i] = -1;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    seed     = 32'hfbd8;
    rst_n    = 1'b0;
    req_en   = 1'b0;
    req      = '0;
    wdata_en = 1'b0;
    wdata_wq = '0;
    wdata    = '0;
    st_stall = 1'b0;
    agu_hold = '0;
    busy     = '0;
    sent     = 0;
    for (int i = 0; i < WQ_ENTRIES; i++) begin
      wait_cnt[i] = -1;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (sent < NUM_REQ || pending_writes() > 0) begin
      @(negedge clk);
      free_slots();
      drive_cycle();
    end
    @(negedge clk);
    req_en   = 1'b0;
    wdata_en = 1'b0;
    agu_hold = '0;
    st_stall = 1'b0;
    wait (seen == NUM_REQ);
    // a few idle cycles to catch stray port activity
    repeat (3) @(negedge clk);
    $display("closing report: %0d errors, %0d of %0d stores checked", errors, seen, NUM_REQ);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, only %0d of %0d stores reached the ports",
             cycles, seen, NUM_REQ);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

  localparam int NUM_BANKS  = 32;
  localparam int BANK_BYTES = 4;

  typedef logic [$clog2(NUM_BANKS)-1:0]  bank_t;
  typedef logic [BANK_BYTES-1:0]         ben_t;
  typedef logic [$clog2(BANK_BYTES)-1:0] byte_off_t;
  typedef logic [NUM_BANKS-1:0]          bank_mask_t;

  // 0: byte, 1: half, 2 and 3: word
  typedef logic [1:0] st_size_t;

  // offset of the last byte, bit 2 set when the store crosses into the next bank
  function automatic logic [2:0] last_off(byte_off_t low, st_size_t size);
    logic [2:0] len_m1;
    case (size)
      2'd0:    len_m1 = 3'd0;
      2'd1:    len_m1 = 3'd1;
      default: len_m1 = 3'd3;
    endcase
    return {1'b0, low} + len_m1;
  endfunction

  function automatic bank_mask_t bank_mask(bank_t bank, logic [2:0] last);
    bank_mask_t m;
    bank_t      nxt;
    nxt = bank + bank_t'(1);
    m   = bank_mask_t'(1) << bank;
    if (last[2]) begin
      m = m | (bank_mask_t'(1) << nxt);
    end
    return m;
  endfunction

endpackage

// File: src/store_commit_top.sv
`timescale 1ns/1ps

module store_commit_top #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_en,
  input  stq_pkg::st_req_t  req,
  output logic              req_full,
  input  logic              wdata_en,
  input  stq_pkg::wq_idx_t  wdata_wq,
  input  stq_pkg::st_data_t wdata,
  input  logic              st_stall,
  input  logic [3:0]        agu_hold,
  output logic              st0_en,
  output stq_pkg::st_port_t st0,
  output logic              st1_en,
  output stq_pkg::st_port_t st1
);
  import stq_pkg::*;

  logic     head0_vld;
  logic     head1_vld;
  st_req_t  head0;
  st_req_t  head1;
  logic     rdy0;
  logic     rdy1;
  st_data_t data0;
  st_data_t data1;
  logic     issue0;
  logic     issue1;

  store_req_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_req_queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (req_en),
    .push_req (req),
    .pop0     (issue0),
    .pop1     (issue1),
    .full     (req_full),
    .head0_vld(head0_vld),
    .head0    (head0),
    .head1_vld(head1_vld),
    .head1    (head1)
  );

  store_data_buf u_data_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wdata_en),
    .wr_wq   (wdata_wq),
    .wr_data (wdata),
    .rd_wq0  (head0.wq),
    .rd_wq1  (head1.wq),
    .clr0    (issue0),
    .clr1    (issue1),
    .rdy0    (rdy0),
    .rd_data0(data0),
    .rdy1    (rdy1),
    .rd_data1(data1)
  );

  store_issue u_issue (
    .clk      (clk),
    .rst_n    (rst_n),
    .head0_vld(head0_vld),
    .head0    (head0),
    .head1_vld(head1_vld),
    .head1    (head1),
    .rdy0     (rdy0),
    .rdy1     (rdy1),
    .agu_hold (agu_hold),
    .st_stall (st_stall),
    .issue0   (issue0),
    .issue1   (issue1)
  );

  store_port_stage u_port_stage (
    .clk   (clk),
    .rst_n (rst_n),
    .issue0(issue0),
    .issue1(issue1),
    .req0  (head0),
    .req1  (head1),
    .data0 (data0),
    .data1 (data1),
    .st0_en(st0_en),
    .st0   (st0),
    .st1_en(st1_en),
    .st1   (st1)
  );

endmodule

// File: src/store_data_buf.sv
`timescale 1ns/1ps

module store_data_buf (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,
  input  stq_pkg::wq_idx_t  wr_wq,
  input  stq_pkg::st_data_t wr_data,
  input  stq_pkg::wq_idx_t  rd_wq0,
  input  stq_pkg::wq_idx_t  rd_wq1,
  input  logic              clr0,
  input  logic              clr1,
  output logic              rdy0,
  output stq_pkg::st_data_t rd_data0,
  output logic              rdy1,
  output stq_pkg::st_data_t rd_data1
);
  import stq_pkg::*;

  st_data_t              data_mem [WQ_ENTRIES];
  logic [WQ_ENTRIES-1:0] rdy_q;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_wq] <= wr_data;
    end
  end

  // clears first so that a write to the same slot wins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= '0;
    end else begin
      if (clr0) begin
        rdy_q[rd_wq0] <= 1'b0;
      end
      if (clr1) begin
        rdy_q[rd_wq1] <= 1'b0;
      end
      if (wr_en) begin
        rdy_q[wr_wq] <= 1'b1;
      end
    end
  end

  assign rdy0     = rdy_q[rd_wq0];
  assign rd_data0 = data_mem[rd_wq0];
  assign rdy1     = rdy_q[rd_wq1];
  assign rd_data1 = data_mem[rd_wq1];

endmodule

// File: src/store_issue.sv
`timescale 1ns/1ps

module store_issue (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             head0_vld,
  input  stq_pkg::st_req_t head0,
  input  logic             head1_vld,
  input  stq_pkg::st_req_t head1,
  input  logic             rdy0,
  input  logic             rdy1,
  input  logic [3:0]       agu_hold,
  input  logic             st_stall,
  output logic             issue0,
  output logic             issue1
);
  import dcache_pkg::*;

  logic       stall_q;
  logic       blocked;
  bank_mask_t mask0;
  bank_mask_t mask1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= st_stall;
    end
  end

  // bus hold, miss hold, miss pause, data insert
  assign blocked = (|agu_hold) || stall_q;

  assign mask0 = bank_mask(head0.addr[6:2], last_off(head0.addr[1:0], head0.size));
  assign mask1 = bank_mask(head1.addr[6:2], last_off(head1.addr[1:0], head1.size));

  assign issue0 = head0_vld && rdy0 && !blocked;

  // second port only when no bank is shared with the first store
  assign issue1 = issue0 && head1_vld && rdy1 && ((mask0 & mask1) == '0);

endmodule

// File: src/store_port_stage.sv
`timescale 1ns/1ps

module store_port_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue0,
  input  logic              issue1,
  input  stq_pkg::st_req_t  req0,
  input  stq_pkg::st_req_t  req1,
  input  stq_pkg::st_data_t data0,
  input  stq_pkg::st_data_t data1,
  output logic              st0_en,
  output stq_pkg::st_port_t st0,
  output logic              st1_en,
  output stq_pkg::st_port_t st1
);
  import dcache_pkg::*;
  import stq_pkg::*;

  logic [1:0] en_q;
  st_req_t    req0_q;
  st_req_t    req1_q;
  st_data_t   data0_q;
  st_data_t   data1_q;

  function automatic st_port_t form_port(st_req_t r, st_data_t d);
    st_port_t   p;
    byte_off_t  low;
    logic [2:0] last;
    logic [1:0] top;
    low  = r.addr[1:0];
    last = last_off(low, r.size);
    // first bank ends at byte 3 when the store spills over
    top  = last[2] ? 2'd3 : last[1:0];
    p.addr = r.addr;
    for (int i = 0; i < BANK_BYTES; i++) begin
      p.bgn_ben[i] = (i >= low) && (i <= top);
      p.end_ben[i] = last[2] && (i <= last[1:0]);
    end
    p.end_bank = r.addr[6:2] + bank_t'(last[2]);
    p.data     = port_data_t'(d) << {low, 3'b000};
    return p;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= 2'b00;
    end else begin
      en_q <= {issue1, issue0};
    end
  end

  always_ff @(posedge clk) begin
    if (issue0) begin
      req0_q  <= req0;
      data0_q <= data0;
    end
    if (issue1) begin
      req1_q  <= req1;
      data1_q <= data1;
    end
  end

  assign st0_en = en_q[0];
  assign st1_en = en_q[1];
  assign st0    = form_port(req0_q, data0_q);
  assign st1    = form_port(req1_q, data1_q);

endmodule

// File: src/store_req_queue.sv
`timescale 1ns/1ps

module store_req_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  stq_pkg::st_req_t push_req,
  input  logic             pop0,
  input  logic             pop1,
  output logic             full,
  output logic             head0_vld,
  output stq_pkg::st_req_t head0,
  output logic             head1_vld,
  output stq_pkg::st_req_t head1
);
  import stq_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_W:0]   DEPTH_P = QUEUE_DEPTH[PTR_W:0];
  localparam logic [CNT_W-1:0] DEPTH_C = QUEUE_DEPTH[CNT_W-1:0];

  st_req_t          mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;
  logic [1:0]       pop_n;

  // pointer advance with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_add(logic [PTR_W-1:0] p, logic [1:0] n);
    logic [PTR_W:0] s;
    s = {1'b0, p} + n;
    if (s >= DEPTH_P) begin
      s = s - DEPTH_P;
    end
    return s[PTR_W-1:0];
  endfunction

  assign full    = (count_q == DEPTH_C);
  assign push_ok = push && !full;
  // pop1 only ever comes with pop0
  assign pop_n   = {1'b0, pop0} + {1'b0, pop1};

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_req;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_q <= '0;
    end else begin
      rd_ptr  <= ptr_add(rd_ptr, pop_n);
      wr_ptr  <= ptr_add(wr_ptr, {1'b0, push_ok});
      count_q <= count_q + CNT_W'(push_ok) - CNT_W'(pop_n);
    end
  end

  // two oldest entries
  assign head0_vld = (count_q != '0);
  assign head1_vld = (count_q > CNT_W'(1));
  assign head0     = mem[rd_ptr];
  assign head1     = mem[ptr_add(rd_ptr, 2'd1)];

endmodule

// File: src/stq_pkg.sv
package stq_pkg;

  localparam int ADDR_W     = 32;
  localparam int WQ_ENTRIES = 16;

  typedef logic [$clog2(WQ_ENTRIES)-1:0] wq_idx_t;
  typedef logic [31:0]                   st_data_t;
  typedef logic [63:0]                   port_data_t;

  // decoded store waiting for commit
  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    dcache_pkg::st_size_t size;
    wq_idx_t              wq;
  } st_req_t;

  // one data cache store port
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    dcache_pkg::ben_t  bgn_ben;
    dcache_pkg::ben_t  end_ben;
    dcache_pkg::bank_t end_bank;
    port_data_t        data;
  } st_port_t;

endpackage
